// File: design/alu_backend_pkg.sv
`default_nettype none

package alu_backend_pkg;

    // datapath widths
    parameter int XLEN   = 32;
    parameter int PREG_W = 6;   // physical register tag
    parameter int OP_W   = 3;

    // alu op codes
    parameter logic [OP_W-1:0] OP_ADD = 3'd0;
    parameter logic [OP_W-1:0] OP_SUB = 3'd1;
    parameter logic [OP_W-1:0] OP_AND = 3'd2;
    parameter logic [OP_W-1:0] OP_OR  = 3'd3;
    parameter logic [OP_W-1:0] OP_XOR = 3'd4;
    parameter logic [OP_W-1:0] OP_SLL = 3'd5;  // shift amount in low 5 bits of src1
    parameter logic [OP_W-1:0] OP_SRL = 3'd6;
    parameter logic [OP_W-1:0] OP_SLT = 3'd7;  // signed compare, 1 or 0

    // operand word as carried from dispatch into the issue queue.
    // a ready operand holds its value, a waiting one holds the tag
    // of the producer in the low bits with zeros above
    typedef union packed {
        logic [XLEN-1:0] value;
        struct packed {
            logic [XLEN-PREG_W-1:0] pad;
            logic [PREG_W-1:0]      tag;
        } pend;
    } operand_u;

endpackage

`default_nettype wire

// File: design/alu_iq.sv
`timescale 1ns/10ps
`default_nettype none

module alu_iq import alu_backend_pkg::*; #(
    parameter int IQ_DEPTH = 4
) (
    input  wire logic              clk,
    input  wire logic              rst_i,
    input  wire logic              flush_i,
    // dispatch
    input  wire logic              disp_valid_i,
    input  wire logic [OP_W-1:0]   disp_op_i,
    input  wire logic [PREG_W-1:0] disp_dst_i,
    input  wire operand_u          disp_src0_i,
    input  wire logic              disp_src0_rdy_i,
    input  wire operand_u          disp_src1_i,
    input  wire logic              disp_src1_rdy_i,
    output logic                   disp_ready_o,
    // wakeup bus
    input  wire logic              cdb_valid_i,
    input  wire logic [PREG_W-1:0] cdb_dst_i,
    input  wire logic [XLEN-1:0]   cdb_data_i,
    // issue
    input  wire logic              exu_ready_i,
    output logic                   issue_valid_o,
    output logic [OP_W-1:0]        issue_op_o,
    output logic [PREG_W-1:0]      issue_dst_o,
    output logic [XLEN-1:0]        issue_a_o,
    output logic [XLEN-1:0]        issue_b_o
);
    localparam int IDX_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;

    logic [IQ_DEPTH-1:0]               ent_valid;
    logic [IQ_DEPTH-1:0]               ent_rdy0;
    logic [IQ_DEPTH-1:0]               ent_rdy1;
    logic [IQ_DEPTH-1:0][IQ_DEPTH-1:0] older;  // older[j][i] set when j came before i
    logic [OP_W-1:0]                   ent_op   [IQ_DEPTH];
    logic [PREG_W-1:0]                 ent_dst  [IQ_DEPTH];
    operand_u                          ent_src0 [IQ_DEPTH];
    operand_u                          ent_src1 [IQ_DEPTH];

    logic [IQ_DEPTH-1:0] rdy_vec;
    logic [IQ_DEPTH-1:0] sel_vec;
    logic [IQ_DEPTH-1:0] wake0;
    logic [IQ_DEPTH-1:0] wake1;
    logic [IDX_W-1:0]    sel_idx;
    logic [IDX_W-1:0]    free_idx;
    logic                disp_fire;
    logic                issue_fire;
    logic                snoop0;
    logic                snoop1;

    assign disp_ready_o = ~&ent_valid;
    assign disp_fire    = disp_valid_i & disp_ready_o;
    assign issue_fire   = issue_valid_o & exu_ready_i;

    // producer broadcasting in the very cycle of dispatch
    assign snoop0 = !disp_src0_rdy_i && cdb_valid_i && (disp_src0_i.pend.tag == cdb_dst_i);
    assign snoop1 = !disp_src1_rdy_i && cdb_valid_i && (disp_src1_i.pend.tag == cdb_dst_i);

    always_comb begin
        free_idx = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i]) free_idx = IDX_W'(i);  // lowest free slot wins
        end
    end

    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            wake0[i] = ent_valid[i] && !ent_rdy0[i] && cdb_valid_i
                       && (ent_src0[i].pend.tag == cdb_dst_i);
            wake1[i] = ent_valid[i] && !ent_rdy1[i] && cdb_valid_i
                       && (ent_src1[i].pend.tag == cdb_dst_i);
        end
    end

    // oldest ready entry: ready and no older ready entry
    always_comb begin
        rdy_vec = ent_valid & ent_rdy0 & ent_rdy1;
        sel_vec = '0;
        sel_idx = '0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            sel_vec[i] = rdy_vec[i];
            for (int j = 0; j < IQ_DEPTH; j++) begin
                if (rdy_vec[j] && older[j][i]) sel_vec[i] = 1'b0;
            end
            if (sel_vec[i]) sel_idx = IDX_W'(i);
        end
    end

    assign issue_valid_o = |rdy_vec;
    assign issue_op_o    = ent_op[sel_idx];
    assign issue_dst_o   = ent_dst[sel_idx];
    assign issue_a_o     = ent_src0[sel_idx].value;
    assign issue_b_o     = ent_src1[sel_idx].value;

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            ent_valid <= '0;
            ent_rdy0  <= '0;
            ent_rdy1  <= '0;
            older     <= '0;
        end else begin
            for (int i = 0; i < IQ_DEPTH; i++) begin
                if (issue_fire && sel_vec[i]) ent_valid[i] <= 1'b0;
                if (wake0[i]) ent_rdy0[i] <= 1'b1;
                if (wake1[i]) ent_rdy1[i] <= 1'b1;
            end
            if (disp_fire) begin
                ent_valid[free_idx] <= 1'b1;
                ent_rdy0[free_idx]  <= disp_src0_rdy_i | snoop0;
                ent_rdy1[free_idx]  <= disp_src1_rdy_i | snoop1;
                for (int j = 0; j < IQ_DEPTH; j++) begin
                    older[free_idx][j] <= 1'b0;          // youngest of all
                    older[j][free_idx] <= ent_valid[j];
                end
            end
        end
    end

    // operand and op storage
    always_ff @(posedge clk) begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (wake0[i]) ent_src0[i].value <= cdb_data_i;
            if (wake1[i]) ent_src1[i].value <= cdb_data_i;
        end
        if (disp_fire) begin
            ent_op[free_idx]         <= disp_op_i;
            ent_dst[free_idx]        <= disp_dst_i;
            ent_src0[free_idx].value <= snoop0 ? cdb_data_i : disp_src0_i.value;
            ent_src1[free_idx].value <= snoop1 ? cdb_data_i : disp_src1_i.value;
        end
    end

    // the issued entry is live with both operands in hand
    a_issue_ready: assert property (@(posedge clk) disable iff (rst_i || flush_i)
        issue_valid_o |-> (ent_valid[sel_idx] && ent_rdy0[sel_idx] && ent_rdy1[sel_idx]));

    // age order stays total over the entries, one oldest ready at a time
    a_one_oldest: assert property (@(posedge clk) disable iff (rst_i || flush_i)
        issue_valid_o |-> $onehot(sel_vec));

endmodule

`default_nettype wire

// File: design/alu_unit.sv
`timescale 1ns/10ps
`default_nettype none

module alu_unit import alu_backend_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_i,
    input  wire logic              flush_i,
    input  wire logic              issue_valid_i,
    input  wire logic [OP_W-1:0]   issue_op_i,
    input  wire logic [PREG_W-1:0] issue_dst_i,
    input  wire logic [XLEN-1:0]   issue_a_i,
    input  wire logic [XLEN-1:0]   issue_b_i,
    input  wire logic              fifo_ready_i,
    output logic                   exu_ready_o,
    output logic                   res_valid_o,
    output logic [PREG_W-1:0]      res_dst_o,
    output logic [XLEN-1:0]        res_data_o
);
    logic [XLEN-1:0] alu_out;

    always_comb begin
        case (issue_op_i)
            OP_ADD:  alu_out = issue_a_i + issue_b_i;
            OP_SUB:  alu_out = issue_a_i - issue_b_i;
            OP_AND:  alu_out = issue_a_i & issue_b_i;
            OP_OR:   alu_out = issue_a_i | issue_b_i;
            OP_XOR:  alu_out = issue_a_i ^ issue_b_i;
            OP_SLL:  alu_out = issue_a_i << issue_b_i[4:0];
            OP_SRL:  alu_out = issue_a_i >> issue_b_i[4:0];
            default: alu_out = {{(XLEN-1){1'b0}}, $signed(issue_a_i) < $signed(issue_b_i)};
        endcase
    end

    // result register free, or drained into the fifo this cycle
    assign exu_ready_o = !res_valid_o || fifo_ready_i;

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            res_valid_o <= 1'b0;
        end else if (exu_ready_o) begin
            res_valid_o <= issue_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (exu_ready_o && issue_valid_i) begin
            res_dst_o  <= issue_dst_i;
            res_data_o <= alu_out;
        end
    end

    // stalled result must survive until the fifo takes it
    a_hold_on_stall: assert property (@(posedge clk) disable iff (rst_i || flush_i)
        (res_valid_o && !fifo_ready_i) |=>
        (res_valid_o && $stable(res_dst_o) && $stable(res_data_o)));

endmodule

`default_nettype wire

// File: design/result_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module result_fifo import alu_backend_pkg::*; #(
    parameter int FIFO_DEPTH = 2
) (
    input  wire logic              clk,
    input  wire logic              rst_i,
    input  wire logic              flush_i,
    input  wire logic              push_i,
    input  wire logic [PREG_W-1:0] push_dst_i,
    input  wire logic [XLEN-1:0]   push_data_i,
    input  wire logic              pop_i,
    output logic                   fifo_ready_o,
    output logic                   head_valid_o,
    output logic [PREG_W-1:0]      head_dst_o,
    output logic [XLEN-1:0]        head_data_o
);
    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [PREG_W-1:0] mem_dst  [FIFO_DEPTH];
    logic [XLEN-1:0]   mem_data [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;

    assign fifo_ready_o = (count != CNT_W'(FIFO_DEPTH));
    assign head_valid_o = (count != '0);  // no bypass, visible one cycle after push
    assign head_dst_o   = mem_dst[rd_ptr];
    assign head_data_o  = mem_data[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop_i)  rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem_dst[wr_ptr]  <= push_dst_i;
            mem_data[wr_ptr] <= push_data_i;
        end
    end

    // producer and arbiter both have to respect the fill level
    a_no_overflow: assert property (@(posedge clk) disable iff (rst_i || flush_i)
        push_i |-> fifo_ready_o);
    a_no_underflow: assert property (@(posedge clk) disable iff (rst_i || flush_i)
        pop_i |-> head_valid_o);

endmodule

`default_nettype wire

// File: design/cdb_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module cdb_arbiter import alu_backend_pkg::*; #(
    parameter int LANES = 2
) (
    input  wire logic                         clk,
    input  wire logic                         rst_i,
    input  wire logic                         flush_i,
    input  wire logic [LANES-1:0]             head_valid_i,
    input  wire logic [LANES-1:0][PREG_W-1:0] head_dst_i,
    input  wire logic [LANES-1:0][XLEN-1:0]   head_data_i,
    output logic [LANES-1:0]                  pop_o,
    output logic                              cdb_valid_o,
    output logic [PREG_W-1:0]                 cdb_dst_o,
    output logic [XLEN-1:0]                   cdb_data_o
);
    localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;

    logic [PTR_W-1:0] rr_ptr;   // lane with first claim this cycle
    logic [PTR_W-1:0] win_idx;
    logic             found;

    // scan lanes starting at the round-robin pointer
    always_comb begin
        int idx;
        found   = 1'b0;
        win_idx = '0;
        pop_o   = '0;
        for (int k = 0; k < LANES; k++) begin
            idx = int'(rr_ptr) + k;
            if (idx >= LANES) idx = idx - LANES;
            if (!found && head_valid_i[idx]) begin
                found   = 1'b1;
                win_idx = PTR_W'(idx);
            end
        end
        if (found) pop_o[win_idx] = 1'b1;
    end

    assign cdb_valid_o = found;
    assign cdb_dst_o   = head_dst_i[win_idx];
    assign cdb_data_o  = head_data_i[win_idx];

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            rr_ptr <= '0;
        end else if (found) begin
            rr_ptr <= (win_idx == PTR_W'(LANES - 1)) ? '0 : win_idx + 1'b1;  // skip past winner
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (rst_i)
        $onehot0(pop_o));

endmodule

`default_nettype wire

// File: design/alu_backend_top.sv
`timescale 1ns/10ps
`default_nettype none

module alu_backend_top import alu_backend_pkg::*; #(
    parameter int IQ_DEPTH   = 4,
    parameter int FIFO_DEPTH = 2,
    parameter int LANES      = 2
) (
    input  wire logic                         clk,
    input  wire logic                         rst_i,
    input  wire logic                         flush_i,
    // per-lane dispatch
    input  wire logic [LANES-1:0]             disp_valid_i,
    input  wire logic [LANES-1:0][OP_W-1:0]   disp_op_i,
    input  wire logic [LANES-1:0][PREG_W-1:0] disp_dst_i,
    input  wire operand_u [LANES-1:0]         disp_src0_i,
    input  wire logic [LANES-1:0]             disp_src0_rdy_i,
    input  wire operand_u [LANES-1:0]         disp_src1_i,
    input  wire logic [LANES-1:0]             disp_src1_rdy_i,
    output logic [LANES-1:0]                  disp_ready_o,
    // common data bus
    output logic                              cdb_valid_o,
    output logic [PREG_W-1:0]                 cdb_dst_o,
    output logic [XLEN-1:0]                   cdb_data_o
);
    logic [LANES-1:0]             issue_valid;
    logic [LANES-1:0][OP_W-1:0]   issue_op;
    logic [LANES-1:0][PREG_W-1:0] issue_dst;
    logic [LANES-1:0][XLEN-1:0]   issue_a;
    logic [LANES-1:0][XLEN-1:0]   issue_b;
    logic [LANES-1:0]             exu_ready;
    logic [LANES-1:0]             res_valid;
    logic [LANES-1:0][PREG_W-1:0] res_dst;
    logic [LANES-1:0][XLEN-1:0]   res_data;
    logic [LANES-1:0]             fifo_ready;
    logic [LANES-1:0]             push;
    logic [LANES-1:0]             head_valid;
    logic [LANES-1:0][PREG_W-1:0] head_dst;
    logic [LANES-1:0][XLEN-1:0]   head_data;
    logic [LANES-1:0]             pop;

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        alu_iq #(
            .IQ_DEPTH(IQ_DEPTH)
        ) u_iq (
            .clk(clk), .rst_i(rst_i), .flush_i(flush_i),
            .disp_valid_i(disp_valid_i[l]),
            .disp_op_i(disp_op_i[l]),
            .disp_dst_i(disp_dst_i[l]),
            .disp_src0_i(disp_src0_i[l]),
            .disp_src0_rdy_i(disp_src0_rdy_i[l]),
            .disp_src1_i(disp_src1_i[l]),
            .disp_src1_rdy_i(disp_src1_rdy_i[l]),
            .disp_ready_o(disp_ready_o[l]),
            .cdb_valid_i(cdb_valid_o),        // wakeup straight off the cdb
            .cdb_dst_i(cdb_dst_o),
            .cdb_data_i(cdb_data_o),
            .exu_ready_i(exu_ready[l]),
            .issue_valid_o(issue_valid[l]),
            .issue_op_o(issue_op[l]),
            .issue_dst_o(issue_dst[l]),
            .issue_a_o(issue_a[l]),
            .issue_b_o(issue_b[l])
        );

        alu_unit u_alu (
            .clk(clk), .rst_i(rst_i), .flush_i(flush_i),
            .issue_valid_i(issue_valid[l]),
            .issue_op_i(issue_op[l]),
            .issue_dst_i(issue_dst[l]),
            .issue_a_i(issue_a[l]),
            .issue_b_i(issue_b[l]),
            .fifo_ready_i(fifo_ready[l]),
            .exu_ready_o(exu_ready[l]),
            .res_valid_o(res_valid[l]),
            .res_dst_o(res_dst[l]),
            .res_data_o(res_data[l])
        );

        assign push[l] = res_valid[l] & fifo_ready[l];

        result_fifo #(
            .FIFO_DEPTH(FIFO_DEPTH)
        ) u_fifo (
            .clk(clk), .rst_i(rst_i), .flush_i(flush_i),
            .push_i(push[l]),
            .push_dst_i(res_dst[l]),
            .push_data_i(res_data[l]),
            .pop_i(pop[l]),
            .fifo_ready_o(fifo_ready[l]),
            .head_valid_o(head_valid[l]),
            .head_dst_o(head_dst[l]),
            .head_data_o(head_data[l])
        );
    end

    cdb_arbiter #(
        .LANES(LANES)
    ) u_arb (
        .clk(clk), .rst_i(rst_i), .flush_i(flush_i),
        .head_valid_i(head_valid),
        .head_dst_i(head_dst),
        .head_data_i(head_data),
        .pop_o(pop),
        .cdb_valid_o(cdb_valid_o),
        .cdb_dst_o(cdb_dst_o),
        .cdb_data_o(cdb_data_o)
    );

endmodule

`default_nettype wire

// File: tb/tb_alu_backend.sv
`timescale 1ns/10ps
`default_nettype none

module tb_alu_backend import alu_backend_pkg::*; ();
    localparam int LANES      = 2;
    localparam int N_OPS      = 8;    // test 1, per lane
    localparam int N_CHAIN    = 9;    // test 2, total
    localparam int N_STRESS   = 30;   // test 3, per lane
    localparam int N_FILL     = 5;    // test 4, total
    localparam int N_FLUSH    = 18;   // test 5, per lane
    localparam int N_TOTAL    = 2 * N_OPS + N_CHAIN + 2 * N_STRESS + N_FILL + 2 * N_FLUSH;
    localparam int WATCHDOG_NS = (N_TOTAL * 10 + 500) * 20;

    logic                         clk;
    logic                         rst_i;
    logic                         flush_i;
    logic [LANES-1:0]             disp_valid_i;
    logic [LANES-1:0][OP_W-1:0]   disp_op_i;
    logic [LANES-1:0][PREG_W-1:0] disp_dst_i;
    operand_u [LANES-1:0]         disp_src0_i;
    logic [LANES-1:0]             disp_src0_rdy_i;
    operand_u [LANES-1:0]         disp_src1_i;
    logic [LANES-1:0]             disp_src1_rdy_i;
    logic [LANES-1:0]             disp_ready_o;
    logic                         cdb_valid_o;
    logic [PREG_W-1:0]            cdb_dst_o;
    logic [XLEN-1:0]              cdb_data_o;

    // scoreboard, indexed by tag
    logic [XLEN-1:0] exp_val [64];
    bit              busy [64];       // allocated, not yet broadcast
    bit              inflight [64];   // accepted by the dut
    bit              broadcast [64];
    bit              flushed [64];
    int              inflight_cnt;
    int              next_tag;
    int              errors;
    int              checks;
    int              test_err;
    int              tests_run;
    int              tests_ok;
    logic [31:0]     lfsr_state;

    // instruction word: op, dst, a is tag, a, b is tag, b
    logic [74:0] q0 [$];
    logic [74:0] q1 [$];

    alu_backend_top uut (
        .clk(clk), .rst_i(rst_i), .flush_i(flush_i),
        .disp_valid_i(disp_valid_i), .disp_op_i(disp_op_i), .disp_dst_i(disp_dst_i),
        .disp_src0_i(disp_src0_i), .disp_src0_rdy_i(disp_src0_rdy_i),
        .disp_src1_i(disp_src1_i), .disp_src1_rdy_i(disp_src1_rdy_i),
        .disp_ready_o(disp_ready_o),
        .cdb_valid_o(cdb_valid_o), .cdb_dst_o(cdb_dst_o), .cdb_data_o(cdb_data_o)
    );

    always #10 clk = ~clk;

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] ref_alu(input logic [2:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            3'd0: return a + b;
            3'd1: return a - b;
            3'd2: return a & b;
            3'd3: return a | b;
            3'd4: return a ^ b;
            3'd5: return a << b[4:0];
            3'd6: return a >> b[4:0];
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    // dep flags mean the operand field holds a producer tag
    task automatic make_instr(input logic [2:0] op, input bit adep, input logic [31:0] a,
                              input bit bdep, input logic [31:0] b, output logic [74:0] ins);
        logic [31:0] va;
        logic [31:0] vb;
        while (busy[next_tag]) next_tag = (next_tag + 1) % 64;
        va = adep ? exp_val[a[5:0]] : a;
        vb = bdep ? exp_val[b[5:0]] : b;
        exp_val[next_tag]   = ref_alu(op, va, vb);
        busy[next_tag]      = 1'b1;
        broadcast[next_tag] = 1'b0;
        flushed[next_tag]   = 1'b0;
        ins = {op, 6'(next_tag), adep, a, bdep, b};
        next_tag = (next_tag + 1) % 64;
    endtask

    task automatic present(input int lane, input logic [74:0] ins, input bit hold_tag);
        logic [5:0] ta;
        logic [5:0] tb;
        ta = ins[38:33];
        tb = ins[5:0];
        disp_valid_i[lane] = 1'b1;
        disp_op_i[lane]    = ins[74:72];
        disp_dst_i[lane]   = ins[71:66];
        if (ins[65] && (hold_tag || !broadcast[ta])) begin
            disp_src0_i[lane].value    = '0;
            disp_src0_i[lane].pend.tag = ta;
            disp_src0_rdy_i[lane]      = 1'b0;
        end else begin
            disp_src0_i[lane].value = ins[65] ? exp_val[ta] : ins[64:33];
            disp_src0_rdy_i[lane]   = 1'b1;
        end
        if (ins[32] && !broadcast[tb]) begin
            disp_src1_i[lane].value    = '0;
            disp_src1_i[lane].pend.tag = tb;
            disp_src1_rdy_i[lane]      = 1'b0;
        end else begin
            disp_src1_i[lane].value = ins[32] ? exp_val[tb] : ins[31:0];
            disp_src1_rdy_i[lane]   = 1'b1;
        end
    endtask

    task automatic accept(input logic [74:0] ins);
        inflight[ins[71:66]] = 1'b1;
        inflight_cnt++;
    endtask

    // offer queue heads on both lanes until empty or out of cycles
    task automatic run_queues(input int max_cycles);
        int  n;
        bit  acc0;
        bit  acc1;
        n = 0;
        while ((q0.size() > 0 || q1.size() > 0) && n < max_cycles) begin
            @(negedge clk);
            disp_valid_i = '0;
            acc0 = 1'b0;
            acc1 = 1'b0;
            if (q0.size() > 0) begin
                present(0, q0[0], 1'b0);
                acc0 = disp_ready_o[0];
            end
            if (q1.size() > 0) begin
                present(1, q1[0], 1'b0);
                acc1 = disp_ready_o[1];
            end
            @(posedge clk);
            if (acc0) accept(q0.pop_front());
            if (acc1) accept(q1.pop_front());
            n++;
        end
        @(negedge clk);
        disp_valid_i = '0;
    endtask

    task automatic wait_drain();
        while (inflight_cnt > 0) @(negedge clk);
    endtask

    task automatic check_ready(input logic [1:0] expect_rdy);
        checks++;
        assert (disp_ready_o == expect_rdy) else begin
            $display("error: disp_ready_o is %h, expected %h", disp_ready_o, expect_rdy);
            errors++;
        end
    endtask

    task automatic flush_pipe();
        @(negedge clk);
        #1;  // after this cycle's compare
        flush_i      = 1'b1;
        disp_valid_i = '0;
        for (int t = 0; t < 64; t++) begin
            if (inflight[t]) flushed[t] = 1'b1;
            inflight[t] = 1'b0;
            busy[t]     = 1'b0;
        end
        inflight_cnt = 0;
        q0.delete();
        q1.delete();
        @(negedge clk);
        flush_i = 1'b0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_err) begin
            tests_ok++;
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: FAILED with %0d errors", tests_run, name, errors - test_err);
        end
        test_err = errors;
    endtask

    // compare every cdb broadcast against the scoreboard
    always @(negedge clk) begin
        if (!rst_i && cdb_valid_o) begin
            checks++;
            assert (inflight[cdb_dst_o]) else begin
                if (flushed[cdb_dst_o])
                    $display("tag %h was flushed but still showed up on the cdb", cdb_dst_o);
                else
                    $display("tag %h on the cdb was not expected or came twice", cdb_dst_o);
                errors++;
            end
            if (inflight[cdb_dst_o]) begin
                assert (cdb_data_o == exp_val[cdb_dst_o]) else begin
                    $display("error: cdb_data_o for cdb_dst_o %h is %h, expected %h",
                             cdb_dst_o, cdb_data_o, exp_val[cdb_dst_o]);
                    errors++;
                end
                inflight[cdb_dst_o]  = 1'b0;
                busy[cdb_dst_o]      = 1'b0;
                broadcast[cdb_dst_o] = 1'b1;
                inflight_cnt--;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the dut stopped making progress", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        logic [74:0] ins;
        logic [74:0] chain [N_CHAIN];
        logic [74:0] prod;
        int          waited;
        clk = 0;
        rst_i = 1;
        flush_i = 0;
        disp_valid_i = '0;
        disp_op_i = '0;
        disp_dst_i = '0;
        disp_src0_i = '0;
        disp_src0_rdy_i = '0;
        disp_src1_i = '0;
        disp_src1_rdy_i = '0;
        lfsr_state = 32'd67562;
        inflight_cnt = 0;
        next_tag = 0;
        errors = 0;
        checks = 0;
        test_err = 0;
        tests_run = 0;
        tests_ok = 0;
        for (int t = 0; t < 64; t++) begin
            exp_val[t] = '0;
            busy[t] = 0;
            inflight[t] = 0;
            broadcast[t] = 0;
            flushed[t] = 0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_i = 0;
        check_ready(2'b11);

        // 1: every op on both lanes, random ready operands
        for (int op = 0; op < N_OPS; op++) begin
            make_instr(3'(op), 0, rand_bits(32), 0, rand_bits(32), ins);
            q0.push_back(ins);
            make_instr(3'(op), 0, rand_bits(32), 0, rand_bits(32), ins);
            q1.push_back(ins);
        end
        run_queues(1000);
        wait_drain();
        end_test("all ops");

        // 2: dependent chain across lanes, then a same-cycle snoop
        make_instr(3'd0, 0, rand_bits(32), 0, rand_bits(32), chain[0]);
        make_instr(3'd1, 1, 32'(chain[0][71:66]), 0, rand_bits(32), chain[1]);
        make_instr(3'd0, 1, 32'(chain[1][71:66]), 1, 32'(chain[1][71:66]), chain[2]);
        make_instr(3'd5, 1, 32'(chain[2][71:66]), 0, rand_bits(5), chain[3]);
        make_instr(3'd3, 1, 32'(chain[0][71:66]), 0, rand_bits(32), chain[4]);
        make_instr(3'd7, 1, 32'(chain[4][71:66]), 1, 32'(chain[1][71:66]), chain[5]);
        make_instr(3'd2, 0, rand_bits(32), 1, 32'(chain[5][71:66]), chain[6]);
        make_instr(3'd6, 1, 32'(chain[3][71:66]), 0, rand_bits(5), chain[7]);
        for (int i = 0; i < 4; i++) q0.push_back(chain[i]);
        for (int i = 4; i < 8; i++) q1.push_back(chain[i]);
        run_queues(1000);
        make_instr(3'd0, 0, rand_bits(32), 0, rand_bits(32), prod);
        q0.push_back(prod);
        run_queues(1000);
        waited = 0;
        while (!(cdb_valid_o && cdb_dst_o == prod[71:66]) && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        make_instr(3'd3, 1, 32'(prod[71:66]), 0, rand_bits(32), chain[8]);
        present(1, chain[8], 1'b1);
        checks++;
        assert (disp_ready_o[1] && waited < 100) else begin
            $display("snoop dispatch could not line up with its producer broadcast");
            errors++;
        end
        @(posedge clk);
        accept(chain[8]);
        @(negedge clk);
        disp_valid_i = '0;
        wait_drain();
        end_test("dependent chain");

        // 3: both lanes dispatch every cycle
        for (int i = 0; i < N_STRESS; i++) begin
            make_instr(3'(rand_bits(3)), 0, rand_bits(32), 0, rand_bits(32), ins);
            q0.push_back(ins);
            make_instr(3'(rand_bits(3)), 0, rand_bits(32), 0, rand_bits(32), ins);
            q1.push_back(ins);
        end
        run_queues(5000);
        wait_drain();
        end_test("full rate");

        // 4: waiters fill lane 0 until their producer broadcasts
        make_instr(3'd0, 0, rand_bits(32), 0, rand_bits(32), prod);
        for (int i = 0; i < 4; i++) begin
            make_instr(3'(rand_bits(3)), 1, 32'(prod[71:66]), 0, rand_bits(32), ins);
            q0.push_back(ins);
        end
        run_queues(100);
        checks++;
        assert (q0.size() == 0) else begin
            $display("lane 0 stopped accepting before its queue was full");
            errors++;
        end
        check_ready(2'b10);
        q1.push_back(prod);
        run_queues(100);
        wait_drain();
        check_ready(2'b11);
        end_test("queue full");

        // 5: flush mid-stream, then fresh work
        for (int i = 0; i < N_FLUSH - 6; i++) begin
            make_instr(3'(rand_bits(3)), 0, rand_bits(32), 0, rand_bits(32), ins);
            q0.push_back(ins);
            make_instr(3'(rand_bits(3)), 0, rand_bits(32), 0, rand_bits(32), ins);
            q1.push_back(ins);
        end
        run_queues(5);
        flush_pipe();
        check_ready(2'b11);
        repeat (10) @(negedge clk);
        for (int i = 0; i < 6; i++) begin
            make_instr(3'(rand_bits(3)), 0, rand_bits(32), 0, rand_bits(32), ins);
            q0.push_back(ins);
            make_instr(3'(rand_bits(3)), 0, rand_bits(32), 0, rand_bits(32), ins);
            q1.push_back(ins);
        end
        run_queues(1000);
        wait_drain();
        end_test("flush");

        $display("%0d of %0d tests passed, %0d checks, %0d errors",
                 tests_ok, tests_run, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
design/alu_backend_pkg.sv
design/alu_iq.sv
design/alu_unit.sv
design/result_fifo.sv
design/cdb_arbiter.sv
design/alu_backend_top.sv
tb/tb_alu_backend.sv

// File: Makefile
# Verilator build and run for the ALU back end testbench

VERILATOR ?= verilator
TOP       ?= tb_alu_backend
BUILD     ?= obj_dir
LOG       ?= sim.log
FLIST     ?= sim.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FLIST))
BIN  := $(BUILD)/$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o $(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q '^Testbench passed$$' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
